// ==== dv/mem_stage_golden.txt ====
# columns, all hex: op rd addr src2 exp_wen exp_rd exp_data
# op codes as in mem_op_e; op c is a nop, its expected columns are unused
0 01 123456789abcdef0 0000000000000000 1 01 123456789abcdef0
0 00 0000000000000055 0000000000000000 0 00 0000000000000055
0 1f 00000000deadbeef 0000000000000000 1 1f 00000000deadbeef
b 00 0000000000000100 0123456789abcdef 0 00 0000000000000000
4 02 0000000000000100 0000000000000000 1 02 0123456789abcdef
c 03 0000000000000000 0000000000000000 0 00 0000000000000000
8 00 0000000000000101 77777777777777aa 0 00 0000000000000000
9 00 0000000000000102 666666666666beef 0 00 0000000000000000
a 00 0000000000000104 55555555fedcba98 0 00 0000000000000000
4 04 0000000000000100 0000000000000000 1 04 fedcba98beefaaef
1 05 0000000000000101 0000000000000000 1 05 ffffffffffffffaa
5 06 0000000000000101 0000000000000000 1 06 00000000000000aa
2 07 0000000000000102 0000000000000000 1 07 ffffffffffffbeef
6 08 0000000000000102 0000000000000000 1 08 000000000000beef
3 09 0000000000000104 0000000000000000 1 09 fffffffffedcba98
7 0a 0000000000000104 0000000000000000 1 0a 00000000fedcba98
c 00 0000000000000000 0000000000000000 0 00 0000000000000000
1 0b 0000000000000100 0000000000000000 1 0b ffffffffffffffef
4 0c 00000000000007f8 0000000000000000 1 0c 0000000000000000
3 0d 0000000000000200 0000000000000000 1 0d 0000000000000000
4 0e 0000000000000900 0000000000000000 1 0e fedcba98beefaaef
4 00 0000000000000100 0000000000000000 0 00 fedcba98beefaaef

// ==== build.f ====
hw/lsu_pkg.sv
hw/axi_lite_pkg.sv
hw/mem_stage_reg.sv
hw/lsu_axi_master.sv
hw/load_extend.sv
hw/axi_lite_ram.sv
hw/mem_stage_top.sv
dv/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_stage_tb -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vmem_stage_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi

// ==== dv/mem_stage_tb.sv ====
/*
 * memory-access stage testbench
 * replays golden instructions into the stage, stalls write-back at random
 * and checks every writeback record against the golden values
 */
module mem_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int wait_limit   = 50;    // cycles per wait before giving up
    localparam int quiet_cycles = 10;    // idle window after the last writeback

    typedef struct packed {
        logic [3:0]           op;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      addr;
        logic [xlen-1:0]      src2;
        logic                 wen;
        logic [reg_idx_w-1:0] exp_rd;
        logic [xlen-1:0]      data;
    } vec_t;

    typedef struct packed {
        logic                 wen;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data;
    } wb_rec_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    mem_op_e              in_op;
    logic [reg_idx_w-1:0] in_rd;
    logic [xlen-1:0]      in_addr;
    logic [xlen-1:0]      in_src2;
    logic                 wb_valid;
    logic                 wb_ready = 1'b0;
    logic                 wb_wen;
    logic [reg_idx_w-1:0] wb_rd;
    logic [xlen-1:0]      wb_data;

    vec_t    vecs[$];                    // golden lines in file order
    wb_rec_t expq[$];                    // records the stage still owes
    wb_rec_t exp_rec;
    wb_rec_t held_rec;                   // record seen under a stall
    logic    held = 1'b0;
    logic [31:0] lfsr_state = 32'd88567;

    mem_stage_top i_dut (.*);

    always #50 clk = ~clk;               // 100 ns period

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h80200003;   // x^32+x^22+x^2+x+1
        else return s >> 1;
    endfunction

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // one lfsr bit per cycle stalls write-back when set
    always @(posedge clk) begin
        lfsr_state = lfsr_next(lfsr_state);
        wb_ready <= !lfsr_state[0];
    end

    task automatic load_golden();
        int    fd;
        int    n;
        string line;
        logic [63:0] f_op, f_rd, f_addr, f_src2, f_wen, f_erd, f_data;
        vec_t  v;
        fd = $fopen("dv/mem_stage_golden.txt", "r");
        if (fd == 0) stop_on_failure("could not open dv/mem_stage_golden.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#") continue;   // column notes
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_op, f_rd, f_addr, f_src2, f_wen, f_erd, f_data);
            if (n != 7) continue;                                    // blank line
            v.op     = f_op[3:0];
            v.rd     = f_rd[reg_idx_w-1:0];
            v.addr   = f_addr;
            v.src2   = f_src2;
            v.wen    = f_wen[0];
            v.exp_rd = f_erd[reg_idx_w-1:0];
            v.data   = f_data;
            vecs.push_back(v);
        end
        $fclose(fd);
        if (vecs.size() == 0) stop_on_failure("the golden file holds no instructions");
    endtask

    // present one instruction and hold it until the stage takes it
    task automatic send_instr(input vec_t v);
        int n;
        @(posedge clk);
        in_valid <= 1'b1;
        in_op    <= mem_op_e'(v.op);
        in_rd    <= v.rd;
        in_addr  <= v.addr;
        in_src2  <= v.src2;
        n = 0;
        @(negedge clk);
        while (!in_ready) begin
            if (n >= wait_limit) stop_on_failure("timeout, in_ready stayed low for 50 cycles");
            n++;
            @(negedge clk);
        end
        if (v.op != op_nop) begin                    // nop never writes back
            expq.push_back(wb_rec_t'{wen: v.wen, rd: v.exp_rd, data: v.data});
        end
    endtask

    // write-back monitor samples mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (held) begin
                assert (wb_valid) else stop_on_failure($sformatf(
                    "ERROR %0t: wb_valid dropped before the handshake", $time));
                assert (wb_wen == held_rec.wen && wb_rd == held_rec.rd &&
                        wb_data == held_rec.data)
                else stop_on_failure($sformatf(
                    "ERROR %0t: writeback record changed while stalled", $time));
            end
            if (wb_valid) begin
                assert (expq.size() != 0) else stop_on_failure($sformatf(
                    "ERROR %0t: writeback with no instruction outstanding", $time));
                exp_rec = expq[0];
                assert (wb_wen == exp_rec.wen) else stop_on_failure($sformatf(
                    "ERROR %0t: wb_wen %0b, expected %0b", $time, wb_wen, exp_rec.wen));
                assert (wb_rd == exp_rec.rd) else stop_on_failure($sformatf(
                    "ERROR %0t: wb_rd %0d, expected %0d", $time, wb_rd, exp_rec.rd));
                assert (wb_data == exp_rec.data) else stop_on_failure($sformatf(
                    "ERROR %0t: wb_data %h, expected %h", $time, wb_data, exp_rec.data));
                if (wb_ready) begin                  // taken on the next edge
                    void'(expq.pop_front());
                    held = 1'b0;
                end else begin
                    held     = 1'b1;
                    held_rec = '{wen: wb_wen, rd: wb_rd, data: wb_data};
                end
            end
        end
    end

    initial begin
        int n;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = op_none;
        in_rd    = '0;
        in_addr  = '0;
        in_src2  = '0;
        load_golden();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        foreach (vecs[i]) send_instr(vecs[i]);
        @(posedge clk);
        in_valid <= 1'b0;                            // execute goes idle
        n = 0;
        while (expq.size() != 0) begin
            if (n >= wait_limit) begin
                stop_on_failure("timeout, writebacks still missing after 50 cycles");
            end
            n++;
            @(negedge clk);
        end
        repeat (quiet_cycles) @(negedge clk);        // a stray writeback trips the monitor
        $display("Test passed");
        $finish;
    end

endmodule

// ==== hw/mem_stage_top.sv ====
/*
 * memory-access stage top
 * stage register, axi master, load aligner and the local data ram
 */
module mem_stage_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  lsu_pkg::mem_op_e                   in_op,
    input  logic [lsu_pkg::reg_idx_w-1:0]      in_rd,
    input  logic [lsu_pkg::xlen-1:0]           in_addr,
    input  logic [lsu_pkg::xlen-1:0]           in_src2,
    output logic                               wb_valid,
    input  logic                               wb_ready,
    output logic                               wb_wen,
    output logic [lsu_pkg::reg_idx_w-1:0]      wb_rd,
    output logic [lsu_pkg::xlen-1:0]           wb_data
);
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    logic                  entry_valid, entry_done, entry_retire;
    mem_op_e               entry_op;
    logic [reg_idx_w-1:0]  entry_rd;
    logic [xlen-1:0]       entry_addr, entry_src2, load_data;

    logic [axi_addr_w-1:0] awaddr, araddr;
    logic [axi_data_w-1:0] wdata, rdata;
    logic [axi_strb_w-1:0] wstrb;
    logic                  awvalid, awready, wvalid, wready, bvalid, bready;
    logic                  arvalid, arready, rvalid, rready;
    axi_resp_e             bresp, rresp;

    mem_stage_reg i_stage_reg (.*);

    lsu_axi_master i_axi_master (.*);

    load_extend i_load_extend (.*);

    axi_lite_ram i_ram (.*);

endmodule

// ==== hw/axi_lite_ram.sv ====
/*
 * axi4-lite data ram
 * 256 words of 64 bits with byte strobes, one-cycle response, always okay
 */
module axi_lite_ram (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [axi_lite_pkg::axi_addr_w-1:0]   awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [axi_lite_pkg::axi_data_w-1:0]   wdata,
    input  logic [axi_lite_pkg::axi_strb_w-1:0]   wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output axi_lite_pkg::axi_resp_e               bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [axi_lite_pkg::axi_addr_w-1:0]   araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [axi_lite_pkg::axi_data_w-1:0]   rdata,
    output axi_lite_pkg::axi_resp_e               rresp,
    output logic                                  rvalid,
    input  logic                                  rready
);
    import axi_lite_pkg::*;

    logic [axi_data_w-1:0] mem [2**(ram_addr_w - 3)];
    logic aw_hs, ar_hs;

    initial begin
        for (int i = 0; i < 2**(ram_addr_w - 3); i++) begin
            mem[i] = '0;                                   // ram starts zeroed
        end
    end

    // address and data only taken together, one write outstanding
    assign awready = awvalid && wvalid && !bvalid;
    assign wready  = awready;
    assign arready = !rvalid;                               // one read outstanding
    assign aw_hs   = awvalid && awready;
    assign ar_hs   = arvalid && arready;
    assign bresp   = resp_okay;
    assign rresp   = resp_okay;

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            for (int i = 0; i < axi_strb_w; i++) begin
                if (wstrb[i]) mem[awaddr[ram_addr_w-1:3]][i*8 +: 8] <= wdata[i*8 +: 8];
            end
        end
        if (ar_hs) rdata <= mem[araddr[ram_addr_w-1:3]];   // upper bits ignored
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (aw_hs) bvalid <= 1'b1;
            else if (bready) bvalid <= 1'b0;               // held until taken
            if (ar_hs) rvalid <= 1'b1;
            else if (rready) rvalid <= 1'b0;
        end
    end

endmodule

// ==== hw/load_extend.sv ====
/*
 * load aligner and writeback former
 * picks the loaded lane, extends it and builds the register write record
 */
module load_extend (
    input  lsu_pkg::mem_op_e                   entry_op,
    input  logic [lsu_pkg::reg_idx_w-1:0]      entry_rd,
    input  logic [lsu_pkg::xlen-1:0]           entry_addr,
    input  logic [lsu_pkg::xlen-1:0]           load_data,
    output logic                               wb_wen,
    output logic [lsu_pkg::reg_idx_w-1:0]      wb_rd,
    output logic [lsu_pkg::xlen-1:0]           wb_data
);
    import lsu_pkg::*;

    logic [2:0]  lane;        // byte offset in the beat
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic [31:0] word_lane;

    assign lane      = entry_addr[2:0];
    assign byte_lane = load_data[{lane, 3'b000} +: 8];
    assign half_lane = load_data[{lane[2:1], 4'b0000} +: 16];   // aligned halves only
    assign word_lane = load_data[{lane[2], 5'b00000} +: 32];

    always_comb begin
        unique case (entry_op)
            op_lb:   wb_data = {{(xlen - 8){byte_lane[7]}}, byte_lane};
            op_lh:   wb_data = {{(xlen - 16){half_lane[15]}}, half_lane};
            op_lw:   wb_data = {{(xlen - 32){word_lane[31]}}, word_lane};
            op_ld:   wb_data = load_data;
            op_lbu:  wb_data = {{(xlen - 8){1'b0}}, byte_lane};
            op_lhu:  wb_data = {{(xlen - 16){1'b0}}, half_lane};
            op_lwu:  wb_data = {{(xlen - 32){1'b0}}, word_lane};
            op_none: wb_data = entry_addr;           // alu result rides in addr
            default: wb_data = '0;                   // stores and nop
        endcase
    end

    // x0 is hardwired, so never enable a write to it
    assign wb_wen = (is_load(entry_op) || (entry_op == op_none)) && (entry_rd != '0);
    assign wb_rd  = entry_rd;

endmodule

// ==== hw/lsu_axi_master.sv ====
/*
 * lsu axi4-lite master
 * issues one read or write per held memory op, shifts store data into its
 * lane, latches the read beat and flags completion to the stage register
 */
module lsu_axi_master (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  entry_valid,
    input  lsu_pkg::mem_op_e                      entry_op,
    input  logic [lsu_pkg::xlen-1:0]              entry_addr,
    input  logic [lsu_pkg::xlen-1:0]              entry_src2,
    input  logic                                  entry_retire,
    output logic                                  entry_done,
    output logic [lsu_pkg::xlen-1:0]              load_data,
    output logic [axi_lite_pkg::axi_addr_w-1:0]   awaddr,
    output logic                                  awvalid,
    input  logic                                  awready,
    output logic [axi_lite_pkg::axi_data_w-1:0]   wdata,
    output logic [axi_lite_pkg::axi_strb_w-1:0]   wstrb,
    output logic                                  wvalid,
    input  logic                                  wready,
    input  axi_lite_pkg::axi_resp_e               bresp,
    input  logic                                  bvalid,
    output logic                                  bready,
    output logic [axi_lite_pkg::axi_addr_w-1:0]   araddr,
    output logic                                  arvalid,
    input  logic                                  arready,
    input  logic [axi_lite_pkg::axi_data_w-1:0]   rdata,
    input  axi_lite_pkg::axi_resp_e               rresp,
    input  logic                                  rvalid,
    output logic                                  rready
);
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_write_req,
        st_write_resp,
        st_read_req,
        st_read_resp,
        st_complete
    } state_e;

    state_e state_q, state_d;
    logic aw_done_q, w_done_q;          // aw and w accepted separately
    logic [2:0] size_m1;                // access bytes minus one
    logic [axi_strb_w-1:0] base_strb;   // strobe before lane shift
    logic is_mem;

    always_comb begin
        unique case (entry_op)
            op_lb, op_lbu, op_sb: begin size_m1 = 3'd0; base_strb = 8'h01; end
            op_lh, op_lhu, op_sh: begin size_m1 = 3'd1; base_strb = 8'h03; end
            op_lw, op_lwu, op_sw: begin size_m1 = 3'd3; base_strb = 8'h0f; end
            op_ld, op_sd:         begin size_m1 = 3'd7; base_strb = 8'hff; end
            default:              begin size_m1 = 3'd0; base_strb = 8'h00; end
        endcase
    end

    assign is_mem = is_load(entry_op) || is_store(entry_op);

    // address and lane-shifted write payload, stable while the entry is held
    assign awaddr = entry_addr[axi_addr_w-1:0];
    assign araddr = entry_addr[axi_addr_w-1:0];
    assign wdata  = entry_src2 << {entry_addr[2:0], 3'b000};
    assign wstrb  = base_strb << entry_addr[2:0];

    assign awvalid = (state_q == st_write_req) && !aw_done_q;
    assign wvalid  = (state_q == st_write_req) && !w_done_q;
    assign bready  = (state_q == st_write_resp);
    assign arvalid = (state_q == st_read_req);
    assign rready  = (state_q == st_read_resp);

    // non-memory ops finish at once
    assign entry_done = (entry_valid && !is_mem) || (state_q == st_complete);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle: begin
                if (entry_valid && is_load(entry_op)) state_d = st_read_req;
                else if (entry_valid && is_store(entry_op)) state_d = st_write_req;
            end
            st_write_req: begin
                if ((aw_done_q || awready) && (w_done_q || wready)) state_d = st_write_resp;
            end
            st_write_resp: if (bvalid) state_d = st_complete;
            st_read_req:   if (arready) state_d = st_read_resp;
            st_read_resp:  if (rvalid) state_d = st_complete;
            st_complete:   if (entry_retire) state_d = st_idle;    // wait for write-back
            default:       state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= st_idle;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == st_write_req) begin
                if (awvalid && awready) aw_done_q <= 1'b1;
                if (wvalid && wready) w_done_q <= 1'b1;
            end else begin
                aw_done_q <= 1'b0;   // ready for the next store
                w_done_q  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid && rready) load_data <= rdata;   // raw beat for the aligner
    end

    // execute never sends a misaligned access
    a_aligned: assert property (@(posedge clk) disable iff (rst)
        entry_valid && is_mem |-> (entry_addr[2:0] & size_m1) == 3'b000);

    a_resp_okay: assert property (@(posedge clk) disable iff (rst)
        !((bvalid && bresp != resp_okay) || (rvalid && rresp != resp_okay)));

    a_b_in_resp: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> state_q == st_write_resp);

endmodule

// ==== hw/mem_stage_reg.sv ====
/*
 * execute-to-memory stage register
 * holds one instruction until it retires and stalls execute meanwhile
 */
module mem_stage_reg (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               in_valid,
    output logic                               in_ready,
    input  lsu_pkg::mem_op_e                   in_op,
    input  logic [lsu_pkg::reg_idx_w-1:0]      in_rd,
    input  logic [lsu_pkg::xlen-1:0]           in_addr,
    input  logic [lsu_pkg::xlen-1:0]           in_src2,
    output logic                               entry_valid,
    output lsu_pkg::mem_op_e                   entry_op,
    output logic [lsu_pkg::reg_idx_w-1:0]      entry_rd,
    output logic [lsu_pkg::xlen-1:0]           entry_addr,
    output logic [lsu_pkg::xlen-1:0]           entry_src2,
    input  logic                               entry_done,
    input  logic                               wb_ready,
    output logic                               wb_valid,
    output logic                               entry_retire
);
    import lsu_pkg::*;

    logic is_nop;

    assign is_nop       = (entry_op == op_nop);
    assign wb_valid     = entry_valid && entry_done && !is_nop;          // nop never shows up
    assign entry_retire = entry_valid && entry_done && (is_nop || wb_ready);
    assign in_ready     = !entry_valid || entry_retire;                  // only stall source

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= 1'b0;
        end else if (in_ready) begin
            entry_valid <= in_valid;                                     // refill or drain
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin                                  // capture on accept
            entry_op   <= in_op;
            entry_rd   <= in_rd;
            entry_addr <= in_addr;
            entry_src2 <= in_src2;
        end
    end

    // a held entry neither changes nor loses entry_done before it retires
    a_entry_stable: assert property (@(posedge clk) disable iff (rst)
        entry_valid && !entry_retire |=> $stable({entry_op, entry_rd, entry_addr, entry_src2})
            && (entry_done || !$past(entry_done)));

endmodule

// ==== hw/axi_lite_pkg.sv ====
/*
 * axi4-lite bus definitions
 * widths, response codes and the size of the data ram
 */
package axi_lite_pkg;

    localparam int axi_addr_w = 32;  // bus address
    localparam int axi_data_w = 64;  // one beat per access
    localparam int axi_strb_w = 8;   // one strobe per byte

    // ram decodes 2 KiB, 256 words of 64 bits
    localparam int ram_addr_w = 11;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

endpackage

// ==== hw/lsu_pkg.sv ====
/*
 * lsu types for the memory-access stage
 * pipeline widths and the access-kind encoding carried from execute
 */
package lsu_pkg;

    localparam int xlen      = 64;  // data and address width
    localparam int reg_idx_w = 5;   // register index width

    // access kind, numeric codes also used by the golden file
    typedef enum logic [3:0] {
        op_none = 4'd0,   // alu result goes to rd
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_ld   = 4'd4,
        op_lbu  = 4'd5,
        op_lhu  = 4'd6,
        op_lwu  = 4'd7,
        op_sb   = 4'd8,
        op_sh   = 4'd9,
        op_sw   = 4'd10,
        op_sd   = 4'd11,
        op_nop  = 4'd12   // bubble, no writeback
    } mem_op_e;

    function automatic logic is_load(mem_op_e op);
        return (op >= op_lb) && (op <= op_lwu);
    endfunction

    function automatic logic is_store(mem_op_e op);
        return (op >= op_sb) && (op <= op_sd);
    endfunction

endpackage
